//--- src/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// ========================================
// datapath sizes
// ========================================
`define EXU_DATA_W   32        // one data word.
`define EXU_REG_NUM  32
`define EXU_IDX_W    5         // log2 of the register count.

// ========================================
// one-hot alu operation
// ========================================
`define EXU_OP_W     12

`define EXU_OP_ADD   0
`define EXU_OP_IMM   1         // pass src1 through unchanged.
`define EXU_OP_OR    2
`define EXU_OP_SUB   3
`define EXU_OP_XOR   4
`define EXU_OP_SRA   5
`define EXU_OP_AND   6
`define EXU_OP_SLL   7
`define EXU_OP_SRL   8
`define EXU_OP_SLTU  9
`define EXU_OP_NOR   10
`define EXU_OP_SLT   11

`endif

//--- src/exu_pkg.sv
`include "exu_consts.svh"

package exu_pkg;

    typedef logic [`EXU_DATA_W-1:0] data_t;
    typedef logic [`EXU_IDX_W-1:0]  reg_idx_t;
    typedef logic [`EXU_OP_W-1:0]   alu_op_t;    // exactly one bit set.

    // command opcodes, register-register forms first.
    typedef enum logic [3:0] {
        CMD_ADD  = 4'h0,
        CMD_SUB  = 4'h1,
        CMD_SLT  = 4'h2,
        CMD_SLTU = 4'h3,
        CMD_AND  = 4'h4,
        CMD_OR   = 4'h5,
        CMD_NOR  = 4'h6,
        CMD_XOR  = 4'h7,
        CMD_SLL  = 4'h8,
        CMD_SRL  = 4'h9,
        CMD_SRA  = 4'ha,
        CMD_ADDI = 4'hb,    // immediate forms.
        CMD_ANDI = 4'hc,
        CMD_ORI  = 4'hd,
        CMD_XORI = 4'he,
        CMD_MOVI = 4'hf
    } exu_cmd_e;

    // output register occupancy.
    typedef enum logic {
        RES_EMPTY = 1'b0,
        RES_FULL  = 1'b1
    } res_state_e;

endpackage

//--- src/alu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module alu (
    input  exu_pkg::alu_op_t alu_op,
    input  exu_pkg::data_t   alu_src1,
    input  exu_pkg::data_t   alu_src2,
    output exu_pkg::data_t   alu_result
);
    import exu_pkg::*;

    logic op_add;
    logic op_imm;
    logic op_or;
    logic op_sub;
    logic op_xor;
    logic op_sra;
    logic op_and;
    logic op_sll;
    logic op_srl;
    logic op_sltu;
    logic op_nor;
    logic op_slt;

    data_t      adder_b;
    data_t      adder_sum;
    logic [4:0] shamt;
    data_t      or_res;
    data_t      and_res;
    data_t      xor_res;
    data_t      nor_res;
    data_t      sll_res;
    data_t      srl_res;
    data_t      sra_res;
    data_t      sltu_res;
    data_t      slt_res;

    assign op_add  = alu_op[`EXU_OP_ADD];
    assign op_imm  = alu_op[`EXU_OP_IMM];
    assign op_or   = alu_op[`EXU_OP_OR];
    assign op_sub  = alu_op[`EXU_OP_SUB];
    assign op_xor  = alu_op[`EXU_OP_XOR];
    assign op_sra  = alu_op[`EXU_OP_SRA];
    assign op_and  = alu_op[`EXU_OP_AND];
    assign op_sll  = alu_op[`EXU_OP_SLL];
    assign op_srl  = alu_op[`EXU_OP_SRL];
    assign op_sltu = alu_op[`EXU_OP_SLTU];
    assign op_nor  = alu_op[`EXU_OP_NOR];
    assign op_slt  = alu_op[`EXU_OP_SLT];

    // one adder for add and sub; sub is a + ~b + 1.
    assign adder_b   = op_sub ? ~alu_src2 : alu_src2;
    assign adder_sum = alu_src1 + adder_b + data_t'(op_sub);

    assign shamt    = alu_src2[4:0];    // low 5 bits only.
    assign or_res   = alu_src1 | alu_src2;
    assign and_res  = alu_src1 & alu_src2;
    assign xor_res  = alu_src1 ^ alu_src2;
    assign nor_res  = ~or_res;
    assign sll_res  = alu_src1 << shamt;
    assign srl_res  = alu_src1 >> shamt;
    assign sra_res  = $signed(alu_src1) >>> shamt;
    assign sltu_res = data_t'(alu_src1 < alu_src2);
    assign slt_res  = data_t'($signed(alu_src1) < $signed(alu_src2));

    // and-or select. nor keeps the plain or/and terms out.
    assign alu_result = ({`EXU_DATA_W{op_add | op_sub}}  & adder_sum) |
                        ({`EXU_DATA_W{op_imm}}           & alu_src1)  |
                        ({`EXU_DATA_W{op_or & ~op_nor}}  & or_res)    |
                        ({`EXU_DATA_W{op_and & ~op_nor}} & and_res)   |
                        ({`EXU_DATA_W{op_xor}}           & xor_res)   |
                        ({`EXU_DATA_W{op_nor}}           & nor_res)   |
                        ({`EXU_DATA_W{op_sll}}           & sll_res)   |
                        ({`EXU_DATA_W{op_srl}}           & srl_res)   |
                        ({`EXU_DATA_W{op_sra}}           & sra_res)   |
                        ({`EXU_DATA_W{op_sltu}}          & sltu_res)  |
                        ({`EXU_DATA_W{op_slt}}           & slt_res);

endmodule

//--- src/op_decoder.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module op_decoder (
    input  exu_pkg::exu_cmd_e cmd_op,
    output exu_pkg::alu_op_t  alu_op,
    output logic              src1_imm,
    output logic              src2_imm
);
    import exu_pkg::*;

    always_comb begin
        alu_op   = '0;    // unknown opcode gives a zero result.
        src1_imm = 1'b0;
        src2_imm = 1'b0;
        case (cmd_op)
            CMD_ADD:  alu_op[`EXU_OP_ADD]  = 1'b1;
            CMD_SUB:  alu_op[`EXU_OP_SUB]  = 1'b1;
            CMD_SLT:  alu_op[`EXU_OP_SLT]  = 1'b1;
            CMD_SLTU: alu_op[`EXU_OP_SLTU] = 1'b1;
            CMD_AND:  alu_op[`EXU_OP_AND]  = 1'b1;
            CMD_OR:   alu_op[`EXU_OP_OR]   = 1'b1;
            CMD_NOR:  alu_op[`EXU_OP_NOR]  = 1'b1;
            CMD_XOR:  alu_op[`EXU_OP_XOR]  = 1'b1;
            CMD_SLL:  alu_op[`EXU_OP_SLL]  = 1'b1;
            CMD_SRL:  alu_op[`EXU_OP_SRL]  = 1'b1;
            CMD_SRA:  alu_op[`EXU_OP_SRA]  = 1'b1;
            // ========================================
            // immediate forms
            // ========================================
            CMD_ADDI: begin
                alu_op[`EXU_OP_ADD] = 1'b1;
                src2_imm            = 1'b1;
            end
            CMD_ANDI: begin
                alu_op[`EXU_OP_AND] = 1'b1;
                src2_imm            = 1'b1;
            end
            CMD_ORI: begin
                alu_op[`EXU_OP_OR] = 1'b1;
                src2_imm           = 1'b1;
            end
            CMD_XORI: begin
                alu_op[`EXU_OP_XOR] = 1'b1;
                src2_imm            = 1'b1;
            end
            CMD_MOVI: begin
                // immediate rides on src1 and passes through.
                alu_op[`EXU_OP_IMM] = 1'b1;
                src1_imm            = 1'b1;
            end
            default: begin
                alu_op = '0;
            end
        endcase
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  exu_pkg::reg_idx_t raddr1,
    input  exu_pkg::reg_idx_t raddr2,
    output exu_pkg::data_t    rdata1,
    output exu_pkg::data_t    rdata2,
    input  logic              we,
    input  exu_pkg::reg_idx_t waddr,
    input  exu_pkg::data_t    wdata
);
    import exu_pkg::*;

    data_t regs [`EXU_REG_NUM];
    logic  wr_en;

    // r0 is never written, so it keeps its reset value of zero.
    assign wr_en = we && (waddr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // read ports, no write-through.
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- src/exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe (
    input  logic              clk,
    input  logic              rst_n,
    // command side
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  exu_pkg::reg_idx_t cmd_rd,
    input  exu_pkg::reg_idx_t cmd_rj,
    input  exu_pkg::reg_idx_t cmd_rk,
    input  exu_pkg::data_t    cmd_imm,
    input  exu_pkg::alu_op_t  alu_op,
    input  logic              src1_imm,
    input  logic              src2_imm,
    // register file
    output exu_pkg::reg_idx_t raddr1,
    output exu_pkg::reg_idx_t raddr2,
    input  exu_pkg::data_t    rdata1,
    input  exu_pkg::data_t    rdata2,
    output logic              we,
    output exu_pkg::reg_idx_t waddr,
    output exu_pkg::data_t    wdata,
    // alu
    output exu_pkg::data_t    alu_src1,
    output exu_pkg::data_t    alu_src2,
    input  exu_pkg::data_t    alu_result,
    // result side
    output logic              res_valid,
    input  logic              res_ready,
    output exu_pkg::data_t    res_data,
    output exu_pkg::reg_idx_t res_rd
);
    import exu_pkg::*;

    res_state_e state;
    res_state_e state_nxt;
    logic       cmd_fire;
    logic       res_fire;
    logic       byp_rj;
    logic       byp_rk;
    data_t      rj_val;
    data_t      rk_val;

    assign res_valid = (state == RES_FULL);
    assign cmd_ready = (state == RES_EMPTY) || res_ready;    // held result may leave this edge.
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign res_fire  = res_valid && res_ready;

    // ========================================
    // operand fetch and bypass
    // ========================================
    assign raddr1 = cmd_rj;
    assign raddr2 = cmd_rk;

    // held result is not in the register file yet.
    assign byp_rj = res_valid && (res_rd != '0) && (res_rd == cmd_rj);
    assign byp_rk = res_valid && (res_rd != '0) && (res_rd == cmd_rk);
    assign rj_val = byp_rj ? res_data : rdata1;
    assign rk_val = byp_rk ? res_data : rdata2;

    assign alu_src1 = src1_imm ? cmd_imm : rj_val;
    assign alu_src2 = src2_imm ? cmd_imm : rk_val;

    // ========================================
    // output register
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            RES_EMPTY: if (cmd_fire) state_nxt = RES_FULL;
            RES_FULL:  if (res_fire && !cmd_fire) state_nxt = RES_EMPTY;
            default:   state_nxt = RES_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RES_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            res_data <= alu_result;
            res_rd   <= cmd_rd;
        end
    end

    // writeback happens on the result handshake.
    assign we    = res_fire;
    assign waddr = res_rd;
    assign wdata = res_data;

endmodule

//--- src/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  exu_pkg::exu_cmd_e cmd_op,
    input  exu_pkg::reg_idx_t cmd_rd,
    input  exu_pkg::reg_idx_t cmd_rj,
    input  exu_pkg::reg_idx_t cmd_rk,
    input  exu_pkg::data_t    cmd_imm,
    output logic              res_valid,
    input  logic              res_ready,
    output exu_pkg::data_t    res_data,
    output exu_pkg::reg_idx_t res_rd
);
    import exu_pkg::*;

    alu_op_t  alu_op;
    logic     src1_imm;
    logic     src2_imm;
    reg_idx_t raddr1;
    reg_idx_t raddr2;
    data_t    rdata1;
    data_t    rdata2;
    logic     we;
    reg_idx_t waddr;
    data_t    wdata;
    data_t    alu_src1;
    data_t    alu_src2;
    data_t    alu_result;

    op_decoder op_decoder_i (
        .cmd_op   (cmd_op),
        .alu_op   (alu_op),
        .src1_imm (src1_imm),
        .src2_imm (src2_imm)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    exec_pipe exec_pipe_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_rd     (cmd_rd),
        .cmd_rj     (cmd_rj),
        .cmd_rk     (cmd_rk),
        .cmd_imm    (cmd_imm),
        .alu_op     (alu_op),
        .src1_imm   (src1_imm),
        .src2_imm   (src2_imm),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_data   (res_data),
        .res_rd     (res_rd)
    );

    alu alu_i (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

endmodule

//--- verification/exu_checker.sv
`timescale 1ns/1ps

module exu_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              cmd_valid,
    input logic              cmd_ready,
    input logic              res_valid,
    input logic              res_ready,
    input exu_pkg::data_t    res_data,
    input exu_pkg::reg_idx_t res_rd,
    input logic              we
);
    int fail_cnt = 0;

    // a held result stays put until it is taken.
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_rd))
        else begin
            $error("result changed under back-pressure");
            fail_cnt++;
        end

    cmd_to_res: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && cmd_ready |=> res_valid)    // one cycle from command to result.
        else begin
            $error("accepted command gave no result on the next cycle");
            fail_cnt++;
        end

    // a written result leaves the slot unless a new command refills it.
    write_drains: assert property (@(posedge clk) disable iff (!rst_n)
        we && !(cmd_valid && cmd_ready) |=> !res_valid)
        else begin
            $error("result still held after its register write");
            fail_cnt++;
        end

endmodule

bind exec_pipe exu_checker exu_checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .res_rd    (res_rd),
    .we        (we)
);

//--- verification/exu_tb.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_tb;
    import exu_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 8;
    localparam int TOTAL_CMDS  = 2000;
    localparam int WATCHDOG_NS = (TOTAL_CMDS * 40 + RST_CYCLES) * CLK_PERIOD;

    localparam int MODE_ZERO = 0;    // add r0, r0.
    localparam int MODE_REG  = 1;
    localparam int MODE_IMM  = 2;
    localparam int MODE_DEP  = 3;    // rj follows the previous rd.
    localparam int MODE_R0   = 4;

    logic     clk;
    logic     rst_n;
    logic     cmd_valid;
    logic     cmd_ready;
    exu_cmd_e cmd_op;
    reg_idx_t cmd_rd;
    reg_idx_t cmd_rj;
    reg_idx_t cmd_rk;
    data_t    cmd_imm;
    logic     res_valid;
    logic     res_ready;
    data_t    res_data;
    reg_idx_t res_rd;

    data_t    model_regs [`EXU_REG_NUM];
    data_t    exp_data_q [$];
    reg_idx_t exp_rd_q [$];
    int       accepted;
    reg_idx_t last_rd;
    logic     hold_cmd;
    string    phase_name;

    exu_cmd_e reg_ops [11] = '{CMD_ADD, CMD_SUB, CMD_SLT, CMD_SLTU, CMD_AND, CMD_OR,
                               CMD_NOR, CMD_XOR, CMD_SLL, CMD_SRL, CMD_SRA};
    exu_cmd_e imm_ops [5]  = '{CMD_ADDI, CMD_ANDI, CMD_ORI, CMD_XORI, CMD_MOVI};

    exu_top exu_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_rd    (cmd_rd),
        .cmd_rj    (cmd_rj),
        .cmd_rk    (cmd_rk),
        .cmd_imm   (cmd_imm),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_rd    (res_rd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: results stopped arriving");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // reference model
    // ========================================
    function automatic data_t model_result(exu_cmd_e op, data_t a, data_t b, data_t imm);
        case (op)
            CMD_ADD:  return a + b;
            CMD_SUB:  return a - b;
            CMD_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            CMD_SLTU: return (a < b) ? 32'd1 : 32'd0;
            CMD_AND:  return a & b;
            CMD_OR:   return a | b;
            CMD_NOR:  return ~(a | b);
            CMD_XOR:  return a ^ b;
            CMD_SLL:  return a << b[4:0];
            CMD_SRL:  return a >> b[4:0];
            CMD_SRA:  return data_t'($signed(a) >>> b[4:0]);
            CMD_ADDI: return a + imm;
            CMD_ANDI: return a & imm;
            CMD_ORI:  return a | imm;
            CMD_XORI: return a ^ imm;
            CMD_MOVI: return imm;
            default:  return '0;
        endcase
    endfunction

    function automatic data_t rand_data();
        int unsigned sel;
        sel = $urandom % 4;
        case (sel)
            0:       return $urandom % 64;                 // small, hits equal compares.
            1:       return 32'h8000_0000 | $urandom;      // sign bit set.
            default: return $urandom;
        endcase
    endfunction

    task automatic value_mismatch(input string what, input data_t exp, input data_t act);
        $display("FAIL %s %s: expected %h, actual %h", phase_name, what, exp, act);
        $display("Done: errors found");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s (phase %s)", msg, phase_name);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    // a failed protocol assertion ends the run right away.
    initial begin
        wait (exu_top_i.exec_pipe_i.exu_checker_i.fail_cnt != 0);
        abort_run("protocol assertion failed");
    end

    task automatic gen_command(input int mode);
        cmd_imm = rand_data();
        cmd_rd  = reg_idx_t'($urandom % 32);
        cmd_rj  = reg_idx_t'($urandom % 32);
        cmd_rk  = reg_idx_t'($urandom % 32);
        cmd_op  = ($urandom % 2) ? reg_ops[$urandom % 11] : imm_ops[$urandom % 5];
        case (mode)
            MODE_ZERO: begin
                cmd_op = CMD_ADD;
                cmd_rj = '0;
                cmd_rk = '0;
            end
            MODE_REG: cmd_op = reg_ops[$urandom % 11];
            MODE_IMM: cmd_op = imm_ops[$urandom % 5];
            MODE_DEP: begin
                cmd_rd = reg_idx_t'(1 + $urandom % 31);
                cmd_rj = last_rd;
                if ($urandom % 2) cmd_rk = last_rd;
            end
            default: begin
                if ($urandom % 2) cmd_rd = '0;
                if ($urandom % 2) cmd_rj = '0;
            end
        endcase
    endtask

    // handshakes are evaluated 1 ns before the rising edge.
    task automatic sample_bus();
        data_t    exp_data;
        reg_idx_t exp_rd;
        if (res_valid && res_ready) begin
            assert (exp_data_q.size() > 0) else abort_run("result with no command outstanding");
            exp_data = exp_data_q.pop_front();
            exp_rd   = exp_rd_q.pop_front();
            assert (res_data == exp_data) else value_mismatch("res_data", exp_data, res_data);
            assert (res_rd == exp_rd)
                else value_mismatch("res_rd", data_t'(exp_rd), data_t'(res_rd));
        end
        if (cmd_valid && cmd_ready) begin
            exp_data = model_result(cmd_op, model_regs[cmd_rj], model_regs[cmd_rk], cmd_imm);
            exp_data_q.push_back(exp_data);
            exp_rd_q.push_back(cmd_rd);
            if (cmd_rd != '0) model_regs[cmd_rd] = exp_data;
            last_rd  = cmd_rd;
            accepted = accepted + 1;
        end
        hold_cmd = cmd_valid && !cmd_ready;
    endtask

    task automatic step_cycle(input int mode, input logic send);
        @(negedge clk);
        if (!hold_cmd) begin
            cmd_valid = send && (($urandom % 100) < 70);
            if (cmd_valid) gen_command(mode);
        end
        res_ready = ($urandom % 100) < 70;
        #(CLK_PERIOD / 2 - 1);
        sample_bus();
    endtask

    task automatic run_phase(input string name, input int mode, input int count);
        int target;
        phase_name = name;
        target     = accepted + count;
        while (accepted < target) step_cycle(mode, 1'b1);
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        void'($urandom(51169));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = CMD_ADD;
        cmd_rd    = '0;
        cmd_rj    = '0;
        cmd_rk    = '0;
        cmd_imm   = '0;
        res_ready = 1'b0;
        accepted  = 0;
        last_rd   = '0;
        hold_cmd  = 1'b0;
        phase_name = "reset";
        model_regs = '{default: '0};
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        assert (!res_valid && cmd_ready) else abort_run("wrong handshake state after reset");

        run_phase("zero_read", MODE_ZERO, 4);
        run_phase("immediate", MODE_IMM, 400);
        run_phase("reg_reg", MODE_REG, 800);
        run_phase("dependency", MODE_DEP, 500);
        run_phase("r0_write", MODE_R0, 296);

        phase_name = "drain";
        do step_cycle(MODE_ZERO, 1'b0); while (res_valid);
        assert (exp_data_q.size() == 0) else abort_run("results missing at end of run");

        if (exu_top_i.exec_pipe_i.exu_checker_i.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("protocol checker failed %0d times",
                     exu_top_i.exec_pipe_i.exu_checker_i.fail_cnt);
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/exu_pkg.sv
src/alu.sv
src/op_decoder.sv
src/reg_file.sv
src/exec_pipe.sv
src/exu_top.sv
verification/exu_checker.sv
verification/exu_tb.sv

//--- Makefile
TOP := exu_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG) || \
		! grep -q "Done: no errors" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
